//--- rtl/adc_ctrl_macros.svh
`ifndef ADC_CTRL_MACROS_SVH
`define ADC_CTRL_MACROS_SVH

// Host trigger byte and data width
`define TRIG_WIDTH      8
`define BYTE_WIDTH      8

// Trigger bit map
`define TRIG_TX_START   0
`define TRIG_TX_LOAD    1
`define TRIG_RUN        2
`define TRIG_STOP       3
`define TRIG_DLY_B0     4
`define TRIG_DLY_B1     5
`define TRIG_DLY_B2     6

// Conversion interval, in system clocks
`define DELAY_WIDTH     22
`define DELAY_RESET     22'd1280

// Setup byte decode
`define CHAN_WIDTH      3
`define SETUP_FLAG_BIT  7

// ADC pin timing
`define CNVST_CYCLES    3
`define SPI_DIV         2

`endif

//--- rtl/adc_ctrl_pkg.sv
`include "adc_ctrl_macros.svh"

package adc_ctrl_pkg;

	// Data byte to and from the ADC
	typedef logic [`BYTE_WIDTH-1:0] byte_t;

	// Channel count or channel index
	typedef logic [`CHAN_WIDTH-1:0] chan_t;

	// Interval between conversion requests
	typedef logic [`DELAY_WIDTH-1:0] delay_t;

	// Sequencer states, one-hot
	typedef enum logic [7:0]
	{
		st_idle       = 8'b0000_0001,
		st_convert    = 8'b0000_0010,
		st_wait_eoc   = 8'b0000_0100,
		st_start_read = 8'b0000_1000,
		st_reading    = 8'b0001_0000,
		st_sample_out = 8'b0010_0000,
		st_next       = 8'b0100_0000,
		st_write_cfg  = 8'b1000_0000
	} seq_state_t;

endpackage

//--- rtl/trigger_decode.sv
`timescale 1ns/1ps
`include "adc_ctrl_macros.svh"

module trigger_decode import adc_ctrl_pkg::*;
(
	input  logic                   CLK_66,
	input  logic                   RST,
	input  logic [`TRIG_WIDTH-1:0] trig,
	input  byte_t                  host_data,
	output logic                   tx_start_pulse,
	output byte_t                  tx_byte,
	output chan_t                  chan_count,
	output logic                   run_pulse,
	output logic                   stop_pulse,
	output delay_t                 interval
);

	logic [`TRIG_WIDTH-1:0] trig_q;
	logic [`TRIG_WIDTH-1:0] trig_d;
	logic [`TRIG_WIDTH-1:0] rise;

	//------------------------------------------------------------
	// Trigger sampling and edge detect
	//------------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			trig_q <= '0;
			trig_d <= '0;
		end
		else
		begin
			trig_q <= trig;
			trig_d <= trig_q;
		end
	end

	// One pulse per rising trigger bit
	assign rise = trig_q & ~trig_d;

	assign tx_start_pulse = rise[`TRIG_TX_START];
	assign run_pulse      = rise[`TRIG_RUN];
	assign stop_pulse     = rise[`TRIG_STOP];

	//------------------------------------------------------------
	// Configuration byte and interval registers
	//------------------------------------------------------------
	always_ff @(posedge CLK_66)
	begin
		if (rise[`TRIG_TX_LOAD])
			tx_byte <= host_data;
	end

	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			chan_count <= `CHAN_WIDTH'd1;
			interval   <= `DELAY_RESET;
		end
		else
		begin
			// Setup byte only when flag bit is set
			if (rise[`TRIG_TX_LOAD] && host_data[`SETUP_FLAG_BIT])
				chan_count <= {1'b0, host_data[4:3]} + `CHAN_WIDTH'd1;
			// Interval loads, low byte first
			if (rise[`TRIG_DLY_B0])
				interval[7:0] <= host_data;
			if (rise[`TRIG_DLY_B1])
				interval[15:8] <= host_data;
			// Top byte is only 6 bits wide
			if (rise[`TRIG_DLY_B2])
				interval[`DELAY_WIDTH-1:16] <= host_data[`DELAY_WIDTH-17:0];
		end
	end

endmodule

//--- rtl/conv_timer.sv
`timescale 1ns/1ps

module conv_timer import adc_ctrl_pkg::*;
(
	input  logic   CLK_66,
	input  logic   RST,
	input  logic   run_pulse,
	input  logic   stop_pulse,
	input  delay_t interval,
	input  logic   conv_ack,
	output logic   conv_req
);

	logic   running;
	delay_t count;

	//------------------------------------------------------------
	// Run flag, interval count and pending request
	//------------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			running  <= 1'b0;
			conv_req <= 1'b0;
			count    <= '0;
		end
		else if (stop_pulse)
		begin
			running  <= 1'b0;
			conv_req <= 1'b0;
			count    <= '0;
		end
		else if (run_pulse)
		begin
			// First request right away
			running  <= 1'b1;
			conv_req <= 1'b1;
			count    <= '0;
		end
		else if (running)
		begin
			if (conv_ack)
			begin
				// Restart the interval from the acknowledge
				conv_req <= 1'b0;
				count    <= '0;
			end
			else if (!conv_req)
			begin
				if (count >= interval)
					conv_req <= 1'b1;
				else
					count <= count + 1'b1;
			end
			// Request held while the sequencer is busy
		end
	end

endmodule

//--- rtl/spi_master.sv
`timescale 1ns/1ps
`include "adc_ctrl_macros.svh"

module spi_master import adc_ctrl_pkg::*;
(
	input  logic  CLK_66,
	input  logic  RST,
	input  logic  spi_start,
	input  byte_t spi_tx,
	output logic  spi_done,
	output byte_t spi_rx,
	output logic  adc_sclk,
	output logic  adc_mosi,
	input  logic  adc_miso,
	output logic  adc_cs_n
);

	localparam int DIV_W = $clog2(`SPI_DIV + 1);
	localparam int BIT_W = $clog2(`BYTE_WIDTH);

	logic             active;
	logic             fin;
	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	byte_t            tx_shift;
	byte_t            rx_shift;

	assign spi_rx = rx_shift;

	//------------------------------------------------------------
	// Mode 0 byte engine, MSB first
	//------------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			active   <= 1'b0;
			fin      <= 1'b0;
			spi_done <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			adc_sclk <= 1'b0;
			adc_mosi <= 1'b0;
			adc_cs_n <= 1'b1;
			tx_shift <= '0;
			rx_shift <= '0;
		end
		else
		begin
			// Done trails chip select by one cycle
			spi_done <= fin;
			fin      <= 1'b0;
			if (!active)
			begin
				if (spi_start)
				begin
					// First bit set up before the first rising SCK
					active   <= 1'b1;
					adc_cs_n <= 1'b0;
					tx_shift <= spi_tx;
					adc_mosi <= spi_tx[`BYTE_WIDTH-1];
					div_cnt  <= '0;
					bit_cnt  <= '0;
				end
			end
			else if (div_cnt == DIV_W'(`SPI_DIV - 1))
			begin
				div_cnt  <= '0;
				adc_sclk <= ~adc_sclk;
				if (!adc_sclk)
				begin
					// Rising edge samples MISO
					rx_shift <= {rx_shift[`BYTE_WIDTH-2:0], adc_miso};
				end
				else if (bit_cnt == BIT_W'(`BYTE_WIDTH - 1))
				begin
					// Last falling edge ends the frame
					active   <= 1'b0;
					adc_cs_n <= 1'b1;
					fin      <= 1'b1;
				end
				else
				begin
					// Falling edge shifts out the next bit
					bit_cnt  <= bit_cnt + 1'b1;
					tx_shift <= tx_shift << 1;
					adc_mosi <= tx_shift[`BYTE_WIDTH-2];
				end
			end
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

//--- rtl/adc_sequencer.sv
`timescale 1ns/1ps
`include "adc_ctrl_macros.svh"

module adc_sequencer import adc_ctrl_pkg::*;
(
	input  logic  CLK_66,
	input  logic  RST,
	input  logic  conv_req,
	output logic  conv_ack,
	input  logic  tx_start_pulse,
	input  byte_t tx_byte,
	input  chan_t chan_count,
	output logic  adc_cnvst_n,
	input  logic  adc_eoc_n,
	output logic  spi_start,
	output byte_t spi_tx,
	input  logic  spi_done,
	input  byte_t spi_rx,
	output byte_t sample_data,
	output logic  sample_valid,
	output chan_t sample_chan,
	output logic  sample_high,
	output logic  busy
);

	localparam int CNV_W = $clog2(`CNVST_CYCLES + 1);

	seq_state_t       state;
	logic [CNV_W-1:0] cnv_cnt;
	logic             eoc_q;
	logic             cfg_pend;
	chan_t            last_chan;

	// Conversion taken only in idle, config write wins
	assign conv_ack = (state == st_idle) && conv_req && !cfg_pend;
	assign busy     = (state != st_idle);

	//------------------------------------------------------------
	// Sequencer FSM
	//------------------------------------------------------------
	always_ff @(posedge CLK_66 or negedge RST)
	begin
		if (!RST)
		begin
			state        <= st_idle;
			cnv_cnt      <= '0;
			eoc_q        <= 1'b1;
			cfg_pend     <= 1'b0;
			last_chan    <= '0;
			adc_cnvst_n  <= 1'b1;
			spi_start    <= 1'b0;
			sample_valid <= 1'b0;
			sample_chan  <= '0;
			sample_high  <= 1'b0;
		end
		else
		begin
			eoc_q        <= adc_eoc_n;
			spi_start    <= 1'b0;
			sample_valid <= 1'b0;
			// Clear on write start, a fresh pulse wins
			if (state == st_idle && cfg_pend)
				cfg_pend <= 1'b0;
			if (tx_start_pulse)
				cfg_pend <= 1'b1;
			case (state)
				st_idle:
				begin
					if (cfg_pend)
					begin
						spi_start <= 1'b1;
						state     <= st_write_cfg;
					end
					else if (conv_req)
					begin
						// Convert-start goes low next cycle
						adc_cnvst_n <= 1'b0;
						cnv_cnt     <= '0;
						last_chan   <= chan_count - 1'b1;
						sample_chan <= '0;
						sample_high <= 1'b1;
						state       <= st_convert;
					end
				end
				st_convert:
				begin
					cnv_cnt <= cnv_cnt + 1'b1;
					if (cnv_cnt == CNV_W'(`CNVST_CYCLES - 1))
					begin
						adc_cnvst_n <= 1'b1;
						state       <= st_wait_eoc;
					end
				end
				st_wait_eoc:
				begin
					// Registered EOC, active low
					if (!eoc_q)
						state <= st_start_read;
				end
				st_start_read:
				begin
					spi_start <= 1'b1;
					state     <= st_reading;
				end
				st_reading:
				begin
					if (spi_done)
					begin
						sample_valid <= 1'b1;
						state        <= st_sample_out;
					end
				end
				st_sample_out:
				begin
					// MSB then LSB of the same channel
					if (sample_high)
					begin
						sample_high <= 1'b0;
						state       <= st_start_read;
					end
					else
						state <= st_next;
				end
				st_next:
				begin
					if (sample_chan == last_chan)
						state <= st_idle;
					else
					begin
						sample_chan <= sample_chan + 1'b1;
						sample_high <= 1'b1;
						state       <= st_start_read;
					end
				end
				st_write_cfg:
				begin
					if (spi_done)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	//------------------------------------------------------------
	// SPI transmit byte and sample capture
	//------------------------------------------------------------
	always_ff @(posedge CLK_66)
	begin
		// Reads clock out zeros
		if (state == st_idle && cfg_pend)
			spi_tx <= tx_byte;
		else if (state == st_start_read)
			spi_tx <= '0;
		if (state == st_reading && spi_done)
			sample_data <= spi_rx;
	end

endmodule

//--- rtl/adc_ctrl_top.sv
`timescale 1ns/1ps
`include "adc_ctrl_macros.svh"

module adc_ctrl_top import adc_ctrl_pkg::*;
(
	input  logic                   CLK_66,
	input  logic                   RST,
	// ADC pins
	output logic                   adc_sclk,
	output logic                   adc_mosi,
	input  logic                   adc_miso,
	output logic                   adc_cs_n,
	output logic                   adc_cnvst_n,
	input  logic                   adc_eoc_n,
	// Host side
	input  logic [`TRIG_WIDTH-1:0] trig,
	input  byte_t                  host_data,
	// Sample stream
	output byte_t                  sample_data,
	output logic                   sample_valid,
	output chan_t                  sample_chan,
	output logic                   sample_high,
	output logic                   busy
);

	logic   tx_start_pulse;
	byte_t  tx_byte;
	chan_t  chan_count;
	logic   run_pulse;
	logic   stop_pulse;
	delay_t interval;
	logic   conv_req;
	logic   conv_ack;
	logic   spi_start;
	byte_t  spi_tx;
	logic   spi_done;
	byte_t  spi_rx;

	//------------------------------------------------------------
	// Host trigger decode
	//------------------------------------------------------------
	trigger_decode u_trigger_decode
	(
		.CLK_66         (CLK_66),
		.RST            (RST),
		.trig           (trig),
		.host_data      (host_data),
		.tx_start_pulse (tx_start_pulse),
		.tx_byte        (tx_byte),
		.chan_count     (chan_count),
		.run_pulse      (run_pulse),
		.stop_pulse     (stop_pulse),
		.interval       (interval)
	);

	// Repeat timer
	conv_timer u_conv_timer
	(
		.CLK_66     (CLK_66),
		.RST        (RST),
		.run_pulse  (run_pulse),
		.stop_pulse (stop_pulse),
		.interval   (interval),
		.conv_ack   (conv_ack),
		.conv_req   (conv_req)
	);

	//------------------------------------------------------------
	// Conversion sequencer and SPI engine
	//------------------------------------------------------------
	adc_sequencer u_adc_sequencer
	(
		.CLK_66         (CLK_66),
		.RST            (RST),
		.conv_req       (conv_req),
		.conv_ack       (conv_ack),
		.tx_start_pulse (tx_start_pulse),
		.tx_byte        (tx_byte),
		.chan_count     (chan_count),
		.adc_cnvst_n    (adc_cnvst_n),
		.adc_eoc_n      (adc_eoc_n),
		.spi_start      (spi_start),
		.spi_tx         (spi_tx),
		.spi_done       (spi_done),
		.spi_rx         (spi_rx),
		.sample_data    (sample_data),
		.sample_valid   (sample_valid),
		.sample_chan    (sample_chan),
		.sample_high    (sample_high),
		.busy           (busy)
	);

	spi_master u_spi_master
	(
		.CLK_66    (CLK_66),
		.RST       (RST),
		.spi_start (spi_start),
		.spi_tx    (spi_tx),
		.spi_done  (spi_done),
		.spi_rx    (spi_rx),
		.adc_sclk  (adc_sclk),
		.adc_mosi  (adc_mosi),
		.adc_miso  (adc_miso),
		.adc_cs_n  (adc_cs_n)
	);

endmodule

//--- bench/adc_model.sv
`timescale 1ns/1ps

module adc_model import adc_ctrl_pkg::*;
(
	input  logic CLK_66,
	input  logic adc_cnvst_n,
	output logic adc_eoc_n,
	input  logic adc_cs_n,
	input  logic adc_sclk,
	input  logic adc_mosi,
	output logic adc_miso
);

	// Conversion time of the modelled ADC, in system clocks
	localparam int EOC_DELAY = 40;

	byte_t miso_q[$];
	byte_t tx_shift;
	byte_t rx_shift;
	byte_t mosi_byte;
	int    frames;

	// Bench fills the answer bytes ahead of time
	task automatic load_byte(input byte_t b);
		miso_q.push_back(b);
	endtask

	//------------------------------------------------------------
	// Convert-start and end of conversion
	//------------------------------------------------------------
	initial
	begin
		adc_eoc_n = 1'b1;
		forever
		begin
			@(negedge adc_cnvst_n);
			@(posedge adc_cnvst_n);
			repeat (EOC_DELAY) @(posedge CLK_66);
			adc_eoc_n <= 1'b0;
			// EOC released by the first chip select
			@(negedge adc_cs_n);
			adc_eoc_n <= 1'b1;
		end
	end

	//------------------------------------------------------------
	// SPI slave, mode 0, MSB first
	//------------------------------------------------------------
	initial
		adc_miso = 1'b0;

	// Every frame takes one byte, write frames too
	always @(negedge adc_cs_n)
	begin
		tx_shift = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
		adc_miso = tx_shift[7];
	end

	// Next bit on each falling SCK
	always @(negedge adc_sclk)
	begin
		if (adc_cs_n == 1'b0)
		begin
			tx_shift = tx_shift << 1;
			adc_miso = tx_shift[7];
		end
	end

	always @(posedge adc_sclk)
	begin
		if (adc_cs_n == 1'b0)
			rx_shift = {rx_shift[6:0], adc_mosi};
	end

	// Frame end, MOSI byte complete
	always @(posedge adc_cs_n)
	begin
		mosi_byte = rx_shift;
		frames    = frames + 1;
	end

endmodule

//--- bench/adc_ctrl_tb.sv
`timescale 1ns/1ps
`include "adc_ctrl_macros.svh"

module adc_ctrl_tb import adc_ctrl_pkg::*;
();

	localparam int SPI_CYCLES = 8 * 2 * `SPI_DIV;
	localparam int EOC_WAIT   = 40;
	localparam int MAX_TESTS  = 32;

	logic                   CLK_66;
	logic                   RST;
	logic [`TRIG_WIDTH-1:0] trig;
	byte_t                  host_data;
	logic                   adc_sclk;
	logic                   adc_mosi;
	logic                   adc_miso;
	logic                   adc_cs_n;
	logic                   adc_cnvst_n;
	logic                   adc_eoc_n;
	byte_t                  sample_data;
	logic                   sample_valid;
	chan_t                  sample_chan;
	logic                   sample_high;
	logic                   busy;

	// Test table from the tests file
	logic [8*12-1:0] cmd_a [0:MAX_TESTS-1];
	logic [31:0]     arg_a [0:MAX_TESTS-1];
	logic [31:0]     exp_a [0:MAX_TESTS-1];
	int              bound_a [0:MAX_TESTS-1];
	int              n_tests = 0;

	byte_t exp_q[$];
	int    errors = 0;
	int    failed = 0;
	int    cycle = 0;
	int    limit = 0;

	// Monitor state
	int   sample_cnt = 0;
	int   seq_idx = 0;
	int   cnv_falls = 0;
	int   low_cnt = 0;
	int   last_fall = -1;
	int   min_gap = 32'h7fff_ffff;
	logic cnv_prev = 1'b1;

	adc_ctrl_top DUT
	(
		.CLK_66       (CLK_66),
		.RST          (RST),
		.adc_sclk     (adc_sclk),
		.adc_mosi     (adc_mosi),
		.adc_miso     (adc_miso),
		.adc_cs_n     (adc_cs_n),
		.adc_cnvst_n  (adc_cnvst_n),
		.adc_eoc_n    (adc_eoc_n),
		.trig         (trig),
		.host_data    (host_data),
		.sample_data  (sample_data),
		.sample_valid (sample_valid),
		.sample_chan  (sample_chan),
		.sample_high  (sample_high),
		.busy         (busy)
	);

	adc_model ADC
	(
		.CLK_66      (CLK_66),
		.adc_cnvst_n (adc_cnvst_n),
		.adc_eoc_n   (adc_eoc_n),
		.adc_cs_n    (adc_cs_n),
		.adc_sclk    (adc_sclk),
		.adc_mosi    (adc_mosi),
		.adc_miso    (adc_miso)
	);

	initial
	begin
		CLK_66 = 1'b0;
		forever
			#50 CLK_66 = ~CLK_66;
	end

	//------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------
	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Cycles for one conversion sequence
	function automatic int seq_bound(input int chans);
		return `CNVST_CYCLES + EOC_WAIT + 20 + 2 * chans * (SPI_CYCLES + 10);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] expv);
		assert (got === expv)
		else
		begin
			$display("Mismatch %0s: got %h expected %h", name, got, expv);
			errors = errors + 1;
		end
	endtask

	// One trigger bit held high for one cycle 10 ns after the edge
	task automatic pulse_trig(input int bit_pos, input byte_t data);
		@(posedge CLK_66);
		#10;
		host_data      = data;
		trig[bit_pos]  = 1'b1;
		@(posedge CLK_66);
		#10;
		trig = '0;
		repeat (2) @(posedge CLK_66);
	endtask

	task automatic wait_idle(input int bound);
		int waited;
		waited = 0;
		while (busy && waited < bound)
		begin
			@(posedge CLK_66);
			waited = waited + 1;
		end
		assert (!busy)
		else
		begin
			$display("Timeout waiting for the sequencer to go idle");
			errors = errors + 1;
		end
	endtask

	task automatic wait_samples(input int target, input int bound);
		int waited;
		waited = 0;
		while (sample_cnt < target && waited < bound)
		begin
			@(posedge CLK_66);
			waited = waited + 1;
		end
		assert (sample_cnt >= target)
		else
		begin
			$display("Timeout waiting for samples, %0d of %0d seen", sample_cnt, target);
			errors = errors + 1;
		end
	endtask

	task automatic wait_falls(input int target, input int bound);
		int waited;
		waited = 0;
		while (cnv_falls < target && waited < bound)
		begin
			@(posedge CLK_66);
			waited = waited + 1;
		end
		assert (cnv_falls >= target)
		else
		begin
			$display("Timeout waiting for convert-start pulses");
			errors = errors + 1;
		end
	endtask

	//------------------------------------------------------------
	// Host commands
	//------------------------------------------------------------
	// Config byte load, then one SPI write frame
	task automatic run_write(input byte_t data, input byte_t expb, input int bound);
		int    f0;
		int    s0;
		int    waited;
		f0 = ADC.frames;
		s0 = sample_cnt;
		pulse_trig(`TRIG_TX_LOAD, data);
		pulse_trig(`TRIG_TX_START, data);
		waited = 0;
		while (ADC.frames == f0 && waited < bound)
		begin
			@(posedge CLK_66);
			waited = waited + 1;
		end
		assert (ADC.frames != f0)
		else
		begin
			$display("Timeout waiting for the configuration write frame");
			errors = errors + 1;
		end
		wait_idle(bound);
		// Model spent one answer byte on the write frame
		exp_q.delete(0);
		check_val("adc_mosi", ADC.mosi_byte, expb);
		assert (sample_cnt == s0)
		else
		begin
			$display("Sample strobe seen during a configuration write");
			errors = errors + 1;
		end
	endtask

	task automatic run_interval(input logic [31:0] value, input logic [31:0] expv);
		pulse_trig(`TRIG_DLY_B0, value[7:0]);
		pulse_trig(`TRIG_DLY_B1, value[15:8]);
		pulse_trig(`TRIG_DLY_B2, value[23:16]);
		check_val("interval", DUT.interval, expv);
	endtask

	// Run then stop gives exactly one sequence
	task automatic run_single(input int expv, input int bound);
		int s0;
		int f0;
		s0 = sample_cnt;
		f0 = cnv_falls;
		pulse_trig(`TRIG_RUN, 8'h00);
		pulse_trig(`TRIG_STOP, 8'h00);
		wait_samples(s0 + expv, bound);
		wait_idle(bound);
		repeat (SPI_CYCLES) @(posedge CLK_66);
		check_val("sample count", sample_cnt - s0, expv);
		check_val("convert-start count", cnv_falls - f0, 1);
	endtask

	task automatic run_repeat(input int pulses, input int min_sp, input int ival,
		input int bound);
		int f0;
		int f1;
		f0        = cnv_falls;
		min_gap   = 32'h7fff_ffff;
		last_fall = -1;
		pulse_trig(`TRIG_RUN, 8'h00);
		wait_falls(f0 + pulses, bound);
		pulse_trig(`TRIG_STOP, 8'h00);
		wait_idle(bound);
		f1 = cnv_falls;
		// Quiet window longer than one interval
		repeat (ival + 20) @(posedge CLK_66);
		assert (cnv_falls == f1)
		else
		begin
			$display("Convert-start pulse seen after stop");
			errors = errors + 1;
		end
		assert (min_gap >= min_sp)
		else
		begin
			$display("Mismatch adc_cnvst_n spacing: got %h expected at least %h",
				min_gap, min_sp);
			errors = errors + 1;
		end
	endtask

	//------------------------------------------------------------
	// Pin monitor, samples and convert-start shape
	//------------------------------------------------------------
	always @(posedge CLK_66)
	begin
		cycle = cycle + 1;
		if (RST === 1'b1)
		begin
			if (sample_valid)
			begin
				check_val("sample_data", sample_data, exp_q.pop_front());
				check_val("sample_chan", sample_chan, seq_idx / 2);
				check_val("sample_high", sample_high, (seq_idx % 2) == 0);
				seq_idx    = seq_idx + 1;
				sample_cnt = sample_cnt + 1;
			end
			if (adc_cnvst_n == 1'b0)
			begin
				if (cnv_prev)
				begin
					// Falling edge starts a new sequence
					if (last_fall >= 0 && cycle - last_fall < min_gap)
						min_gap = cycle - last_fall;
					last_fall = cycle;
					cnv_falls = cnv_falls + 1;
					seq_idx   = 0;
				end
				low_cnt = low_cnt + 1;
			end
			else if (!cnv_prev)
			begin
				check_val("adc_cnvst_n low cycles", low_cnt, `CNVST_CYCLES);
				assert (adc_eoc_n == 1'b1)
				else
				begin
					$display("End of conversion went low during convert-start");
					errors = errors + 1;
				end
				low_cnt = 0;
			end
			cnv_prev = adc_cnvst_n;
		end
	end

	// Run limit from the summed test bounds
	initial
	begin
		wait (limit > 0);
		while (cycle <= limit)
			@(posedge CLK_66);
		$display("Timeout, run passed its limit of %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		int              fd;
		int              n;
		int              i;
		int              chans;
		int              ival;
		int              total;
		int              err0;
		int unsigned     lcg;
		byte_t           b;
		logic [8*80-1:0] line;
		logic [8*12-1:0] cmd;
		logic [31:0]     arg;
		logic [31:0]     expv;

		RST       = 1'b0;
		trig      = '0;
		host_data = '0;

		// Model answers and expected samples from one LCG stream
		lcg = 83;
		for (i = 0; i < 256; i = i + 1)
		begin
			lcg = lcg_next(lcg);
			b   = lcg[23:16];
			ADC.load_byte(b);
			exp_q.push_back(b);
		end

		fd = $fopen("bench/adc_ctrl_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the tests file");
			errors = errors + 1;
		end
		else
		begin
			while (!$feof(fd) && n_tests < MAX_TESTS)
			begin
				line = '0;
				cmd  = '0;
				n    = $fgets(line, fd);
				n    = $sscanf(line, "%s %h %h", cmd, arg, expv);
				if (n >= 3 && cmd != "#")
				begin
					cmd_a[n_tests] = cmd;
					arg_a[n_tests] = arg;
					exp_a[n_tests] = expv;
					n_tests        = n_tests + 1;
				end
			end
			$fclose(fd);
		end

		// Per-test bounds from channel count, interval and SPI length
		chans = 1;
		ival  = `DELAY_RESET;
		total = 0;
		for (i = 0; i < n_tests; i = i + 1)
		begin
			if (cmd_a[i] == "WRITE" || cmd_a[i] == "SETUP")
				bound_a[i] = 2 * SPI_CYCLES + 60;
			else if (cmd_a[i] == "INTERVAL")
				bound_a[i] = 40;
			else if (cmd_a[i] == "SINGLE")
				bound_a[i] = seq_bound(chans) + SPI_CYCLES + 40;
			else
				bound_a[i] = (arg_a[i] + 1) * (ival + seq_bound(chans)) + 80;
			if (cmd_a[i] == "SETUP")
				chans = exp_a[i];
			if (cmd_a[i] == "INTERVAL")
				ival = exp_a[i];
			total = total + bound_a[i];
		end
		limit = total + 500;

		repeat (5) @(posedge CLK_66);
		#10;
		RST = 1'b1;
		repeat (2) @(posedge CLK_66);

		// Reset state
		check_val("adc_cs_n", adc_cs_n, 1'b1);
		check_val("adc_cnvst_n", adc_cnvst_n, 1'b1);
		check_val("adc_sclk", adc_sclk, 1'b0);
		check_val("busy", busy, 1'b0);
		check_val("sample_valid", sample_valid, 1'b0);
		check_val("interval", DUT.interval, `DELAY_RESET);
		check_val("chan_count", DUT.chan_count, 1);
		if (errors != 0)
			failed = failed + 1;
		$display("test 0 RESET %s", (errors == 0) ? "passed" : "FAILED");

		ival = `DELAY_RESET;
		for (i = 0; i < n_tests; i = i + 1)
		begin
			err0 = errors;
			if (cmd_a[i] == "WRITE")
				run_write(arg_a[i][7:0], exp_a[i][7:0], bound_a[i]);
			else if (cmd_a[i] == "SETUP")
			begin
				run_write(arg_a[i][7:0], arg_a[i][7:0], bound_a[i]);
				check_val("chan_count", DUT.chan_count, exp_a[i]);
			end
			else if (cmd_a[i] == "INTERVAL")
			begin
				run_interval(arg_a[i], exp_a[i]);
				ival = exp_a[i];
			end
			else if (cmd_a[i] == "SINGLE")
				run_single(exp_a[i], bound_a[i]);
			else if (cmd_a[i] == "RUN")
				run_repeat(arg_a[i], exp_a[i], ival, bound_a[i]);
			else
			begin
				$display("Unknown command in the tests file");
				errors = errors + 1;
			end
			if (errors != err0)
				failed = failed + 1;
			$display("test %0d %0s %s", i + 1, cmd_a[i], (errors == err0) ? "passed" : "FAILED");
		end

		$display("tests %0d, failed %0d, errors %0d", n_tests + 1, failed, errors);
		if (errors == 0 && failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- bench/adc_ctrl_tests.txt
# Columns: command, operand (hex), expected (hex)
# WRITE data mosi | SETUP data channels | INTERVAL value interval
# SINGLE unused samples | RUN pulses min_spacing
WRITE 5a 5a
WRITE 3c 3c
SETUP 98 4
SINGLE 0 8
SETUP 08 4
SINGLE 0 8
SETUP 88 2
SINGLE 0 4
INTERVAL ffffff 3fffff
INTERVAL 000190 000190
RUN 3 190
SETUP 80 1
SINGLE 0 2

//--- adc_ctrl.f
+incdir+rtl
rtl/adc_ctrl_pkg.sv
rtl/trigger_decode.sv
rtl/conv_timer.sv
rtl/spi_master.sv
rtl/adc_sequencer.sv
rtl/adc_ctrl_top.sv
bench/adc_model.sv
bench/adc_ctrl_tb.sv

//--- Bender.yml
package:
  name: adc_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/adc_ctrl_pkg.sv
      - rtl/trigger_decode.sv
      - rtl/conv_timer.sv
      - rtl/spi_master.sv
      - rtl/adc_sequencer.sv
      - rtl/adc_ctrl_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/adc_model.sv
      - bench/adc_ctrl_tb.sv
